// ==== design/mgr_settings.svh ====
`ifndef MGR_SETTINGS_SVH
`define MGR_SETTINGS_SVH

// ------------------------------
// Work-unit memory
`define MGR_WU_ADDR_W       8    // Word address bits
`define MGR_WU_DEPTH        256  // Words of WU storage
`define MGR_WU_OPT_PER_WORD 2    // Option tuples in one option word

// ------------------------------
// Host bus
`define MGR_AXIL_ADDR_W     12
`define MGR_AXIL_DATA_W     32

// ------------------------------
// Stack bus OOB and status
`define MGR_OOB_DATA_W      28   // Same as the WU body
`define MGR_CNT_W           16   // Issued instruction count

`endif

// ==== design/mgr_bus_pkg.sv ====
`include "mgr_settings.svh"

package mgr_bus_pkg;

  // Stream delineator used on every valid/ready stream
  typedef enum logic [1:0] {
    MOD     = 2'b00,  // Middle of data
    SOD     = 2'b01,  // Start of data
    EOD     = 2'b10,  // End of data
    SOD_EOD = 2'b11   // Single beat packet
  } std_cntl_e;

  typedef enum logic {
    OOB_CFG = 1'b0,  // Header beat
    OOB_OPT = 1'b1   // Option tuple beat
  } oob_type_e;

  // One beat on the downstream OOB port
  typedef struct packed {
    std_cntl_e                  cntl;
    oob_type_e                  oob_type;
    logic [`MGR_OOB_DATA_W-1:0] data;
  } oob_beat_t;

  // AXI4-Lite, host to manager
  typedef struct packed {
    logic [`MGR_AXIL_ADDR_W-1:0]   aw_addr;
    logic                          aw_valid;
    logic [`MGR_AXIL_DATA_W-1:0]   w_data;
    logic [`MGR_AXIL_DATA_W/8-1:0] w_strb;
    logic                          w_valid;
    logic                          b_ready;
    logic [`MGR_AXIL_ADDR_W-1:0]   ar_addr;
    logic                          ar_valid;
    logic                          r_ready;
  } axil_req_t;

  // AXI4-Lite, manager to host
  typedef struct packed {
    logic                        aw_ready;
    logic                        w_ready;
    logic [1:0]                  b_resp;
    logic                        b_valid;
    logic                        ar_ready;
    logic [`MGR_AXIL_DATA_W-1:0] r_data;
    logic [1:0]                  r_resp;
    logic                        r_valid;
  } axil_rsp_t;

endpackage

// ==== design/mgr_wu_pkg.sv ====
`include "mgr_settings.svh"

package mgr_wu_pkg;

  // Instruction kind carried on every word
  typedef enum logic [1:0] {
    NOP = 2'b00,
    OP  = 2'b01,  // Compute, the only kind sent on OOB
    MR  = 2'b10,  // Memory read
    MW  = 2'b11   // Memory write
  } wu_op_e;

  // Start word view
  typedef struct packed {
    logic [7:0] tag;
    logic [5:0] num_lanes;
    logic [6:0] stop_cmd;
    logic [6:0] simd_cmd;
  } wu_inst_t;

  // One option tuple, opt_type of zero is an empty slot
  typedef struct packed {
    logic [5:0] opt_type;
    logic [7:0] opt_value;
  } wu_opt_t;

  // Body bits, decoded by the word position in the instruction
  typedef union packed {
    wu_inst_t                                inst;  // Start word
    wu_opt_t [`MGR_WU_OPT_PER_WORD-1:0]      opt;   // Option word, slot 0 first
  } wu_body_u;

  typedef struct packed {
    mgr_bus_pkg::std_cntl_e cntl;  // Instruction delineator
    wu_op_e                 op;
    wu_body_u               body;
  } wu_word_t;

  // Host control toward fetch
  typedef struct packed {
    logic                      run;         // Single cycle start
    logic [`MGR_WU_ADDR_W-1:0] start_addr;
    logic [`MGR_WU_ADDR_W:0]   length;      // Words, up to full memory
  } mgr_ctrl_t;

  typedef struct packed {
    logic                  busy;
    logic                  done;
    logic [`MGR_CNT_W-1:0] issued;
  } mgr_status_t;

endpackage

// ==== design/mgr_cfg_regs.sv ====
`include "mgr_settings.svh"

module mgr_cfg_regs (
  input  logic                      clk,
  input  logic                      reset,
  input  mgr_bus_pkg::axil_req_t    axil_req,
  output mgr_bus_pkg::axil_rsp_t    axil_rsp,
  output mgr_wu_pkg::mgr_ctrl_t     ctrl,
  input  mgr_wu_pkg::mgr_status_t   status,
  output logic                      wr_en,
  output logic [`MGR_WU_ADDR_W-1:0] wr_addr,
  output mgr_wu_pkg::wu_word_t      wr_word
);

  localparam int AW = `MGR_AXIL_ADDR_W;
  localparam int DW = `MGR_AXIL_DATA_W;
  localparam int SW = `MGR_AXIL_DATA_W / 8;

  localparam logic [AW-1:0] ADDR_CTRL   = 'h000;
  localparam logic [AW-1:0] ADDR_START  = 'h004;
  localparam logic [AW-1:0] ADDR_LEN    = 'h008;
  localparam logic [AW-1:0] ADDR_STATUS = 'h00C;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic          wr_hs;     // AW and W taken together
  logic          rd_hs;
  logic          wr_win;    // Address in the WU window
  logic          wr_ok;
  logic          rd_ok;
  logic [DW-1:0] rd_value;
  logic [DW-1:0] start_wr;  // START after byte strobes
  logic [DW-1:0] len_wr;
  logic          b_valid;
  logic [1:0]    b_resp;
  logic          r_valid;
  logic [DW-1:0] r_data;
  logic [1:0]    r_resp;

  function automatic logic [DW-1:0] merge_strb(
    input logic [DW-1:0] old_v,
    input logic [DW-1:0] new_v,
    input logic [SW-1:0] strb
  );
    logic [DW-1:0] res;
    res = old_v;
    for (int i = 0; i < SW; i++)
      if (strb[i])
        res[8*i +: 8] = new_v[8*i +: 8];
    return res;
  endfunction

  // ------------------------------
  // Address decode
  always_comb
  begin
    wr_hs    = axil_req.aw_valid && axil_req.w_valid && !b_valid;
    rd_hs    = axil_req.ar_valid && !r_valid;
    wr_win   = (axil_req.aw_addr[AW-1:10] == 'd1) && (axil_req.aw_addr[1:0] == 2'b00);
    start_wr = merge_strb(DW'(ctrl.start_addr), axil_req.w_data, axil_req.w_strb);
    len_wr   = merge_strb(DW'(ctrl.length), axil_req.w_data, axil_req.w_strb);
    case (axil_req.aw_addr)
      ADDR_CTRL, ADDR_START, ADDR_LEN: wr_ok = 1'b1;
      default: wr_ok = wr_win && !status.busy && (&axil_req.w_strb);  // STATUS is read-only
    endcase
    rd_ok    = 1'b1;
    rd_value = '0;
    case (axil_req.ar_addr)
      ADDR_CTRL:  rd_value = '0;                 // run clears itself
      ADDR_START: rd_value = DW'(ctrl.start_addr);
      ADDR_LEN:   rd_value = DW'(ctrl.length);
      ADDR_STATUS:
      begin
        rd_value[0]                  = status.busy;
        rd_value[1]                  = status.done;
        rd_value[DW-1 -: `MGR_CNT_W] = status.issued;
      end
      default: rd_ok = 1'b0;  // Window is write-only
    endcase
  end

  // WU window write port
  assign wr_en   = wr_hs && wr_win && wr_ok;
  assign wr_addr = axil_req.aw_addr[2 +: `MGR_WU_ADDR_W];
  assign wr_word = axil_req.w_data;

  // ------------------------------
  // Control registers and channel valids
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ctrl    <= '0;
      b_valid <= 1'b0;
      r_valid <= 1'b0;
    end
    else
    begin
      ctrl.run <= 1'b0;  // Pulse
      if (wr_hs)
      begin
        b_valid <= 1'b1;
        case (axil_req.aw_addr)
          ADDR_CTRL:  ctrl.run <= axil_req.w_strb[0] && axil_req.w_data[0] && !status.busy;
          ADDR_START: ctrl.start_addr <= start_wr[`MGR_WU_ADDR_W-1:0];
          ADDR_LEN:   ctrl.length <= len_wr[`MGR_WU_ADDR_W:0];
          default: ;
        endcase
      end
      else if (axil_req.b_ready)
        b_valid <= 1'b0;
      if (rd_hs)
        r_valid <= 1'b1;
      else if (axil_req.r_ready)
        r_valid <= 1'b0;
    end
  end

  // Response payload
  always_ff @(posedge clk)
  begin
    if (wr_hs)
      b_resp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    if (rd_hs)
    begin
      r_data <= rd_ok ? rd_value : '0;
      r_resp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  always_comb
  begin
    axil_rsp.aw_ready = wr_hs;  // Only with W
    axil_rsp.w_ready  = wr_hs;
    axil_rsp.b_resp   = b_resp;
    axil_rsp.b_valid  = b_valid;
    axil_rsp.ar_ready = !r_valid;
    axil_rsp.r_data   = r_data;
    axil_rsp.r_resp   = r_resp;
    axil_rsp.r_valid  = r_valid;
  end

endmodule

// ==== design/wu_fetch.sv ====
`include "mgr_settings.svh"

module wu_fetch (
  input  logic                      clk,
  input  logic                      reset,
  input  mgr_wu_pkg::mgr_ctrl_t     ctrl,
  input  logic                      stall,     // From WU memory
  output logic                      rd_en,
  output logic [`MGR_WU_ADDR_W-1:0] rd_addr,
  output logic                      fetching
);

  logic [`MGR_WU_ADDR_W:0] remain;  // Reads still to issue

  // ------------------------------
  // Address and count
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rd_addr <= '0;
      remain  <= '0;
    end
    else if (ctrl.run)
    begin
      rd_addr <= ctrl.start_addr;
      remain  <= ctrl.length;
    end
    else if (rd_en)
    begin
      rd_addr <= rd_addr + 1'b1;  // Wraps at top of memory
      remain  <= remain - 1'b1;
    end
  end

  assign fetching = (remain != '0);
  assign rd_en    = fetching && !stall;  // One read per free cycle

endmodule

// ==== design/wu_memory.sv ====
`include "mgr_settings.svh"

module wu_memory (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      wr_en,      // Host window write
  input  logic [`MGR_WU_ADDR_W-1:0] wr_addr,
  input  mgr_wu_pkg::wu_word_t      wr_word,
  input  logic                      rd_en,
  input  logic [`MGR_WU_ADDR_W-1:0] rd_addr,
  output logic                      stall,
  output logic                      word_valid,
  output mgr_wu_pkg::wu_word_t      word,
  input  logic                      word_ready
);
  import mgr_wu_pkg::*;

  wu_word_t mem [`MGR_WU_DEPTH];

  // Storage and read register
  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_word;
    if (rd_en)
      word <= mem[rd_addr];
  end

  // ------------------------------
  // Output register state
  always_ff @(posedge clk)
  begin
    if (reset)
      word_valid <= 1'b0;
    else if (rd_en)
      word_valid <= 1'b1;  // New word replaces one being taken
    else if (word_ready)
      word_valid <= 1'b0;
  end

  assign stall = word_valid && !word_ready;  // Full and held

endmodule

// ==== design/wu_decode.sv ====
`include "mgr_settings.svh"

module wu_decode (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   word_valid,
  input  mgr_wu_pkg::wu_word_t   word,
  output logic                   word_ready,
  output logic                   beat_valid,
  output mgr_bus_pkg::oob_beat_t beat,
  input  logic                   beat_ready,
  output logic                   in_inst
);
  import mgr_bus_pkg::*;
  import mgr_wu_pkg::*;

  localparam int OOB_W     = `MGR_OOB_DATA_W;
  localparam int LAST_SLOT = `MGR_WU_OPT_PER_WORD - 1;
  localparam int SLOT_W    = $clog2(`MGR_WU_OPT_PER_WORD);

  logic              in_op;       // Inside an OP instruction
  logic [SLOT_W-1:0] slot;        // Tuple of the held option word
  logic              hold_valid;  // Latest beat of the packet
  logic              hold_final;  // Its cntl is known and it is offered
  logic              hold_hdr;
  oob_beat_t         hold_beat;
  oob_beat_t         cand_beat;
  wu_opt_t           cur_opt;
  logic              is_start;
  logic              cand_valid;
  logic              last_step;   // This step closes the instruction
  logic              step;
  logic              promote;
  logic              advance;

  function automatic std_cntl_e pick_cntl(input logic hdr, input logic closing);
    if (closing)
      return hdr ? SOD_EOD : EOD;
    return hdr ? SOD : MOD;
  endfunction

  // ------------------------------
  // Candidate beat from the current word
  always_comb
  begin
    is_start   = (word.cntl == SOD) || (word.cntl == SOD_EOD);
    cur_opt    = word.body.opt[slot];
    cand_beat  = '0;
    cand_valid = 1'b0;
    last_step  = 1'b0;
    if (is_start)
    begin
      cand_valid         = (word.op == OP);  // NOP, MR and MW give nothing
      cand_beat.oob_type = OOB_CFG;
      cand_beat.data     = word.body.inst;
      last_step          = (word.cntl == SOD_EOD);
    end
    else if (in_op)
    begin
      cand_valid         = (cur_opt.opt_type != '0);  // Empty slot
      cand_beat.oob_type = OOB_OPT;
      cand_beat.data     = OOB_W'(cur_opt);
      last_step          = (word.cntl == EOD) && (slot == SLOT_W'(LAST_SLOT));
    end
    cand_beat.cntl = pick_cntl(is_start, last_step);
    step    = word_valid && (!hold_valid || !hold_final || beat_ready);
    promote = step && hold_valid && !hold_final && (cand_valid || last_step);
    advance = step && !(hold_valid && !hold_final && cand_valid);  // else wait one beat
  end

  assign word_ready = advance && (is_start || !in_op || slot == SLOT_W'(LAST_SLOT));
  assign beat_valid = hold_valid && hold_final;
  assign beat       = hold_beat;
  assign in_inst    = in_op || hold_valid;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      in_op      <= 1'b0;
      slot       <= '0;
      hold_valid <= 1'b0;
      hold_final <= 1'b0;
    end
    else
    begin
      if (advance && is_start)
        in_op <= (word.op == OP) && (word.cntl == SOD);
      else if (advance && in_op)
      begin
        slot <= (slot == SLOT_W'(LAST_SLOT)) ? '0 : slot + 1'b1;
        if (last_step)
          in_op <= 1'b0;
      end
      if (promote)
        hold_final <= 1'b1;
      else if (advance && cand_valid)
      begin
        hold_valid <= 1'b1;
        hold_final <= last_step;
      end
      else if (beat_valid && beat_ready)
        hold_valid <= 1'b0;
    end
  end

  // Held beat payload
  always_ff @(posedge clk)
  begin
    if (promote)
      hold_beat.cntl <= pick_cntl(hold_hdr, !cand_valid);  // Closes when nothing follows
    else if (advance && cand_valid)
    begin
      hold_beat <= cand_beat;
      hold_hdr  <= is_start;
    end
  end

endmodule

// ==== design/oob_downstream_cntl.sv ====
`include "mgr_settings.svh"

module oob_downstream_cntl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   beat_valid,
  input  mgr_bus_pkg::oob_beat_t beat,
  output logic                   beat_ready,
  output logic                   oob_valid,
  output mgr_bus_pkg::oob_beat_t oob_beat,
  input  logic                   oob_ready,
  input  logic                   clear,       // Run pulse
  output logic [`MGR_CNT_W-1:0]  issued,
  output logic                   pending
);
  import mgr_bus_pkg::*;

  logic last_out;  // Beat on the port closes a packet

  assign beat_ready = !oob_valid || oob_ready;
  assign pending    = oob_valid;
  assign last_out   = (oob_beat.cntl == EOD) || (oob_beat.cntl == SOD_EOD);

  // ------------------------------
  // Output register
  always_ff @(posedge clk)
  begin
    if (reset)
      oob_valid <= 1'b0;
    else if (beat_ready)
      oob_valid <= beat_valid;  // Steady until taken
  end

  always_ff @(posedge clk)
  begin
    if (beat_valid && beat_ready)
      oob_beat <= beat;
  end

  // Instructions sent since the last run
  always_ff @(posedge clk)
  begin
    if (reset || clear)
      issued <= '0;
    else if (oob_valid && oob_ready && last_out)
      issued <= issued + 1'b1;
  end

endmodule

// ==== design/manager.sv ====
`include "mgr_settings.svh"

module manager (
  input  logic                   clk,
  input  logic                   reset,
  input  mgr_bus_pkg::axil_req_t axil_req,
  output mgr_bus_pkg::axil_rsp_t axil_rsp,
  output logic                   oob_valid,
  output mgr_bus_pkg::oob_beat_t oob_beat,
  input  logic                   oob_ready
);
  import mgr_bus_pkg::*;
  import mgr_wu_pkg::*;

  mgr_ctrl_t                 ctrl;
  mgr_status_t               status;
  logic                      wr_en;
  logic [`MGR_WU_ADDR_W-1:0] wr_addr;
  wu_word_t                  wr_word;
  logic                      rd_en;
  logic [`MGR_WU_ADDR_W-1:0] rd_addr;
  logic                      stall;
  logic                      fetching;
  logic                      word_valid;
  wu_word_t                  word;
  logic                      word_ready;
  logic                      beat_valid;
  oob_beat_t                 beat;
  logic                      beat_ready;
  logic                      in_inst;
  logic [`MGR_CNT_W-1:0]     issued;
  logic                      pending;
  logic                      busy;
  logic                      busy_q;
  logic                      done;

  // ------------------------------
  // Status collection
  assign busy   = ctrl.run || fetching || word_valid || in_inst || pending;
  assign status = '{busy: busy, done: done, issued: issued};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy_q <= 1'b0;
      done   <= 1'b0;
    end
    else
    begin
      busy_q <= busy;
      if (ctrl.run)
        done <= 1'b0;
      else if (busy_q && !busy)
        done <= 1'b1;  // Pipeline drained
    end
  end

  // ------------------------------
  // Host registers and WU path
  mgr_cfg_regs mgr_cfg_regs_i (.clk (clk), .reset (reset), .axil_req (axil_req),
    .axil_rsp (axil_rsp), .ctrl (ctrl), .status (status), .wr_en (wr_en),
    .wr_addr (wr_addr), .wr_word (wr_word));

  wu_fetch wu_fetch_i (.clk (clk), .reset (reset), .ctrl (ctrl), .stall (stall),
    .rd_en (rd_en), .rd_addr (rd_addr), .fetching (fetching));

  wu_memory wu_memory_i (.clk (clk), .reset (reset), .wr_en (wr_en), .wr_addr (wr_addr),
    .wr_word (wr_word), .rd_en (rd_en), .rd_addr (rd_addr), .stall (stall),
    .word_valid (word_valid), .word (word), .word_ready (word_ready));

  wu_decode wu_decode_i (.clk (clk), .reset (reset), .word_valid (word_valid),
    .word (word), .word_ready (word_ready), .beat_valid (beat_valid), .beat (beat),
    .beat_ready (beat_ready), .in_inst (in_inst));

  // Stack bus OOB driver
  oob_downstream_cntl oob_downstream_cntl_i (.clk (clk), .reset (reset),
    .beat_valid (beat_valid), .beat (beat), .beat_ready (beat_ready),
    .oob_valid (oob_valid), .oob_beat (oob_beat), .oob_ready (oob_ready),
    .clear (ctrl.run), .issued (issued), .pending (pending));

endmodule

// ==== tests/manager_tb.sv ====
`include "mgr_settings.svh"

module manager_tb;
  import mgr_bus_pkg::*;
  import mgr_wu_pkg::*;

  localparam logic [11:0] ADDR_CTRL   = 12'h000;
  localparam logic [11:0] ADDR_START  = 12'h004;
  localparam logic [11:0] ADDR_LEN    = 12'h008;
  localparam logic [11:0] ADDR_STATUS = 12'h00C;
  localparam logic [11:0] ADDR_WIN    = 12'h400;  // WU window base
  localparam logic [1:0]  OKAY        = 2'b00;
  localparam logic [1:0]  SLVERR      = 2'b10;
  localparam int          N_PROG      = 5;
  localparam int          CYCLES_PER_WORD = 200;

  logic        clk = 1'b0;
  logic        reset;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  logic        oob_valid;
  oob_beat_t   oob_beat;
  logic        oob_ready;

  logic [31:0] prog_q[$];         // Words of current program
  oob_beat_t   prog_beats[$];     // Beats one run should give
  int          prog_ops;          // OP instructions in program
  oob_beat_t   exp_q[$];          // Still expected on the port
  int          budget = 500;      // Watchdog limit in cycles
  logic        prev_valid = 1'b0; // Port state seen last falling edge
  logic        prev_ready = 1'b0;
  oob_beat_t   prev_beat;

  manager dut_i (
    .clk       (clk),
    .reset     (reset),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .oob_valid (oob_valid),
    .oob_beat  (oob_beat),
    .oob_ready (oob_ready)
  );

  always #5 clk = ~clk;

  // ------------------------------
  // Checks
  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic fail_run(input string msg);
    $display("Error at %0t: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  // ------------------------------
  // Host bus tasks called on a falling edge
  task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    axil_req.aw_addr  = addr;
    axil_req.w_data   = data;
    axil_req.w_strb   = '1;
    axil_req.aw_valid = 1'b1;
    axil_req.w_valid  = 1'b1;
    do
      @(posedge clk);
    while (!(axil_rsp.aw_ready || axil_rsp.w_ready));
    check_value("axil_rsp.aw_ready", axil_rsp.aw_ready, 1'b1);  // AW and W taken together
    check_value("axil_rsp.w_ready", axil_rsp.w_ready, 1'b1);
    @(negedge clk);
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    check_value("axil_rsp.b_valid", axil_rsp.b_valid, 1'b1);  // B one cycle after AW/W
    resp              = axil_rsp.b_resp;
  endtask

  task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    axil_req.ar_addr  = addr;
    axil_req.ar_valid = 1'b1;
    do
      @(posedge clk);
    while (!axil_rsp.ar_ready);
    @(negedge clk);
    axil_req.ar_valid = 1'b0;
    check_value("axil_rsp.r_valid", axil_rsp.r_valid, 1'b1);  // Data one cycle after AR
    data              = axil_rsp.r_data;
    resp              = axil_rsp.r_resp;
  endtask

  function automatic logic [11:0] win_addr(input logic [7:0] wu_addr);
    return ADDR_WIN + {wu_addr, 2'b00};  // One word per 4 bytes
  endfunction

  // ------------------------------
  // Program model
  task automatic append_instruction();
    wu_op_e      kind;
    std_cntl_e   cntl;
    int          n_opt;
    int          r;
    logic [27:0] body;
    logic [5:0]  typ;
    oob_beat_t   beat;
    oob_beat_t   pkt[$];
    r     = $urandom % 8;
    kind  = (r < 4) ? OP : (r == 4) ? NOP : (r == 5) ? MR : MW;  // OP half the time
    n_opt = $urandom % 4;
    body  = $urandom;
    cntl  = (n_opt == 0) ? SOD_EOD : SOD;
    prog_q.push_back({cntl, kind, body});
    beat.cntl     = MOD;
    beat.oob_type = OOB_CFG;  // Header is the whole body
    beat.data     = body;
    pkt.push_back(beat);
    for (int j = 0; j < n_opt; j++)
    begin
      for (int s = 0; s < 2; s++)
      begin
        typ = ($urandom % 4 == 0) ? 6'd0 : 6'($urandom % 63 + 1);  // Some slots empty
        body[14*s +: 14] = {typ, 8'($urandom)};
        if (typ != 6'd0)
        begin
          beat.oob_type = OOB_OPT;
          beat.data     = {14'd0, body[14*s +: 14]};
          pkt.push_back(beat);
        end
      end
      cntl = (j == n_opt - 1) ? EOD : MOD;
      prog_q.push_back({cntl, kind, body});
    end
    if (kind == OP)  // Only OP reaches the port
    begin
      prog_ops++;
      beat      = pkt[0];
      beat.cntl = (pkt.size() == 1) ? SOD_EOD : SOD;
      pkt[0]    = beat;
      if (pkt.size() > 1)
      begin
        beat                = pkt[pkt.size()-1];
        beat.cntl           = EOD;  // Closes the packet
        pkt[pkt.size()-1]   = beat;
      end
      foreach (pkt[k])
        prog_beats.push_back(pkt[k]);
    end
  endtask

  task automatic build_program(input int n_inst);
    prog_q.delete();
    prog_beats.delete();
    prog_ops = 0;
    repeat (n_inst)
      append_instruction();
  endtask

  task automatic load_program(input logic [7:0] start);
    logic [1:0] resp;
    foreach (prog_q[i])
    begin
      axil_write(win_addr(8'(start + i)), prog_q[i], resp);  // Wraps at top
      check_value("b_resp window load", resp, OKAY);
    end
  endtask

  task automatic run_program(input logic [7:0] start);
    logic [31:0] data;
    logic [1:0]  resp;
    budget += CYCLES_PER_WORD * prog_q.size();
    foreach (prog_beats[k])
      exp_q.push_back(prog_beats[k]);
    axil_write(ADDR_START, {24'd0, start}, resp);
    check_value("b_resp START", resp, OKAY);
    axil_write(ADDR_LEN, prog_q.size(), resp);
    check_value("b_resp LEN", resp, OKAY);
    axil_write(ADDR_CTRL, 32'd1, resp);
    check_value("b_resp CTRL", resp, OKAY);
    // Locked while running
    axil_write(win_addr(start), ~prog_q[0], resp);
    check_value("b_resp window busy", resp, SLVERR);
    axil_read(ADDR_STATUS, data, resp);
    check_value("status.busy", data[0], 1'b1);
    do
      axil_read(ADDR_STATUS, data, resp);
    while (!(data[1] && !data[0]));
    repeat (20) @(negedge clk);  // Port must stay quiet
    axil_read(ADDR_STATUS, data, resp);
    check_value("status.done", data[1], 1'b1);
    check_value("status.busy", data[0], 1'b0);
    check_value("status.issued", data[31:16], prog_ops);
    check_value("beats left", exp_q.size(), 0);
  endtask

  // ------------------------------
  // OOB port sampled and driven on the falling edge
  initial
  begin : oob_monitor
    oob_beat_t exp;
    forever
    begin
      @(negedge clk);
      if (prev_valid && prev_ready)  // Transferred at last rising edge
      begin
        if (exp_q.size() == 0)
          fail_run("OOB beat transferred while no beat was expected");
        exp = exp_q.pop_front();
        check_value("oob_beat.cntl", prev_beat.cntl, exp.cntl);
        check_value("oob_beat.oob_type", prev_beat.oob_type, exp.oob_type);
        check_value("oob_beat.data", prev_beat.data, exp.data);
      end
      else if (prev_valid)
      begin
        check_value("oob_valid", oob_valid, 1'b1);  // Held until taken
        check_value("oob_beat", oob_beat, prev_beat);
      end
      prev_valid = oob_valid;
      prev_beat  = oob_beat;
      oob_ready  = ($urandom % 10) >= 3;  // Low 30 %
      prev_ready = oob_ready;
    end
  end

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < budget)
    begin
      @(negedge clk);
      cycles++;
    end
    $display("Watchdog expired after %0d cycles, the run did not finish", cycles);
    $display("TESTS FAILED");
    $fatal(1);
  end

  // ------------------------------
  // Main sequence
  initial
  begin : main
    logic [31:0] data;
    logic [1:0]  resp;
    logic [7:0]  start;
    logic [8:0]  len;
    void'($urandom(32'h9e56_920d));
    reset             = 1'b1;
    axil_req          = '0;
    axil_req.b_ready  = 1'b1;
    axil_req.r_ready  = 1'b1;
    oob_ready         = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    axil_read(ADDR_STATUS, data, resp);  // Idle after reset
    check_value("status after reset", data, 32'd0);
    start = $urandom;
    len   = $urandom;
    axil_write(ADDR_START, {24'd0, start}, resp);
    axil_read(ADDR_START, data, resp);
    check_value("START", data, {24'd0, start});
    axil_write(ADDR_LEN, {23'd0, len}, resp);
    axil_read(ADDR_LEN, data, resp);
    check_value("LEN", data, {23'd0, len});
    axil_read(ADDR_CTRL, data, resp);
    check_value("CTRL", data, 32'd0);
    check_value("r_resp CTRL", resp, OKAY);
    axil_read(12'h010, data, resp);
    check_value("r_resp unmapped", resp, SLVERR);
    axil_write(12'h014, 32'h1234_5678, resp);
    check_value("b_resp unmapped", resp, SLVERR);
    axil_read(win_addr(8'h10), data, resp);  // Window is write-only
    check_value("r_resp window", resp, SLVERR);

    for (int p = 0; p < N_PROG; p++)
    begin
      start = (p == 1) ? 8'hFC : 8'($urandom);  // Program 1 wraps memory
      build_program(6 + $urandom % 7);
      load_program(start);
      run_program(start);
      run_program(start);  // Same beats again
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+design
design/mgr_bus_pkg.sv
design/mgr_wu_pkg.sv
design/mgr_cfg_regs.sv
design/wu_fetch.sv
design/wu_memory.sv
design/wu_decode.sv
design/oob_downstream_cntl.sv
design/manager.sv
tests/manager_tb.sv

// ==== Bender.yml ====
package:
  name: manager

sources:
  - include_dirs:
      - design
    files:
      - design/mgr_bus_pkg.sv
      - design/mgr_wu_pkg.sv
      - design/mgr_cfg_regs.sv
      - design/wu_fetch.sv
      - design/wu_memory.sv
      - design/wu_decode.sv
      - design/oob_downstream_cntl.sv
      - design/manager.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/manager_tb.sv
